// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module racing_game_tb \
		-f all.f -o racing_game_sim
	./obj_dir/racing_game_sim | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
game_pkg.sv
joy_integrator.sv
collision_detector.sv
speed_governor.sv
enemy_patrol.sv
racing_game_core.sv
tb_clock_gen.sv
racing_game_assertions.sv
racing_game_tb.sv

// ==== collision_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module collision_detector (
	input wire logic clk100hz,
	input wire logic reset,
	input game_pkg::player_cmd_t cmd,
	input wire logic cmd_valid,
	input game_pkg::pos_t enemy_x,
	input game_pkg::pos_t enemy_y,
	output game_pkg::hit_cmd_t hit,
	output logic hit_valid
);

	game_pkg::pos_t dist_x;
	game_pkg::pos_t dist_y;
	logic overlap;

	function automatic game_pkg::pos_t abs_diff(input game_pkg::pos_t a, input game_pkg::pos_t b);
		return (a >= b) ? a - b : b - a;
	endfunction

	// 16x16 bounding boxes overlap when both distances are under one car
	always_comb
	begin
		dist_x = abs_diff(cmd.player_x, enemy_x);
		dist_y = abs_diff(game_pkg::PLAYER_Y, enemy_y);
		overlap = (dist_x < game_pkg::CAR_SIZE) && (dist_y < game_pkg::CAR_SIZE);
	end

	always_ff @(posedge clk100hz)
	begin
		if (cmd_valid)
			hit <= '{player_x: cmd.player_x, target: cmd.target, collided: overlap};
	end

	always_ff @(posedge clk100hz)
	begin
		if (reset)
			hit_valid <= 1'b0;
		else
			hit_valid <= cmd_valid;
	end

endmodule

`default_nettype wire

// ==== enemy_patrol.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_patrol (
	input wire logic clk100hz,
	input wire logic reset,
	input game_pkg::speed_t speed,
	input game_pkg::track_t track_pos,
	input game_pkg::pos_t player_x,
	input wire logic collided,
	input wire logic step_valid,
	output game_pkg::game_state_t state,
	output logic state_valid
);

	// 1 = moving right, 0 = moving left
	logic enemy_dir;
	logic at_edge;
	logic next_dir;

	// the enemy position lives in the state register itself
	assign at_edge = (state.enemy_x == game_pkg::ENEMY_X_MIN) ||
		(state.enemy_x == game_pkg::ENEMY_X_MAX);
	assign next_dir = enemy_dir ^ at_edge;

	always_ff @(posedge clk100hz)
	begin
		if (reset)
		begin
			enemy_dir <= 1'b0;
			state.player_x <= game_pkg::START_X;
			state.enemy_x <= game_pkg::START_X;
			state.enemy_y <= game_pkg::ENEMY_Y_INIT;
			state.speed <= game_pkg::SPEED_INIT;
			state.track_pos <= '0;
			state.collided <= 1'b0;
		end
		else if (step_valid)
		begin
			enemy_dir <= next_dir;
			state.enemy_x <= next_dir ? state.enemy_x + 10'd1 : state.enemy_x - 10'd1;
			// enemy drifts down with the new speed and wraps at 1024
			state.enemy_y <= state.enemy_y + {6'd0, speed[7:4]};
			state.player_x <= player_x;
			state.speed <= speed;
			state.track_pos <= track_pos;
			state.collided <= collided;
		end
	end

	always_ff @(posedge clk100hz)
	begin
		if (reset)
			state_valid <= 1'b0;
		else
			state_valid <= step_valid;
	end

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

	// basic coordinate and counter types
	typedef logic [9:0] pos_t;
	typedef logic [7:0] speed_t;
	typedef logic [15:0] track_t;

	// visible screen area
	localparam int H_DISPLAY = 640;
	localparam int V_DISPLAY = 480;

	localparam pos_t CAR_SIZE = 10'd16;
	// the player car always sits near the bottom of the screen
	localparam pos_t PLAYER_Y = pos_t'(V_DISPLAY - 64);
	localparam pos_t JOY_X_MAX = pos_t'(H_DISPLAY) - CAR_SIZE;
	localparam pos_t JOY_Y_MIN = 10'd16;
	localparam pos_t JOY_Y_MAX = 10'd128;
	localparam pos_t ENEMY_X_MIN = 10'd64;
	localparam pos_t ENEMY_X_MAX = pos_t'(H_DISPLAY - 64);

	// start positions, both cars centered horizontally
	localparam pos_t START_X = pos_t'(H_DISPLAY / 2);
	localparam pos_t ENEMY_Y_INIT = pos_t'(V_DISPLAY / 8);

	localparam speed_t SPEED_INIT = 8'd31;
	localparam speed_t SPEED_CRASH = 8'd16;

	// stage 1 output, target is the joystick y used as wanted speed
	typedef struct packed {
		pos_t player_x;
		pos_t target;
	} player_cmd_t;

	// stage 2 output
	typedef struct packed {
		pos_t player_x;
		pos_t target;
		logic collided;
	} hit_cmd_t;

	// one complete frame result
	typedef struct packed {
		pos_t player_x;
		pos_t enemy_x;
		pos_t enemy_y;
		speed_t speed;
		track_t track_pos;
		logic collided;
	} game_state_t;

endpackage

`default_nettype wire

// ==== game_vectors.txt ====
// ctrl rep player_x enemy_x enemy_y speed track_pos collided (all hex)
// ctrl: high nibble left right up down, low nibble ignore_valid check_fields valid tick
04 3 140 140 3c 1f 0 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 140 13f 3d 1e 1 0
80 190 0 0 0 0 0 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 000 13e 3e 1d 2 0
40 2bc 0 0 0 0 0 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 270 13d 3f 1c 3 0
10 c8 0 0 0 0 0 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 270 13c 40 1d 4 0
01 4 0 0 0 0 0 0
07 1 270 13b 41 1e 5 0
07 1 270 13a 42 1f 6 0
06 1 270 139 44 20 7 0
06 1 270 138 46 21 9 0
06 1 270 137 48 22 b 0
06 1 270 136 4a 23 d 0
20 c8 0 0 0 0 0 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 270 135 4c 22 f 0
10 8 0 0 0 0 0 0
09 f5 0 0 0 0 0 0
08 3 0 0 0 0 0 0
06 1 270 40 143 17 107 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 270 41 144 18 108 0
09 5b 0 0 0 0 0 0
08 3 0 0 0 0 0 0
06 1 270 9c 19f 17 163 0
80 1d3 0 0 0 0 0 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 9d 9d 1a0 10 164 1
40 1f4 0 0 0 0 0 0
09 1a3 0 0 0 0 0 0
08 3 0 0 0 0 0 0
06 1 270 240 343 17 307 0
01 1 0 0 0 0 0 0
00 3 0 0 0 0 0 0
06 1 270 23f 344 18 308 0
09 bf 0 0 0 0 0 0
08 3 0 0 0 0 0 0
06 1 270 180 3 17 3c7 0
ff 0 0 0 0 0 0

// ==== joy_integrator.sv ====
`timescale 1ns/1ps
`default_nettype none

module joy_integrator (
	input wire logic clk100hz,
	input wire logic reset,
	input wire logic left,
	input wire logic right,
	input wire logic up,
	input wire logic down,
	input wire logic frame_tick,
	output game_pkg::player_cmd_t cmd,
	output logic cmd_valid
);

	// joystick position, moves every cycle a button is held
	game_pkg::pos_t joy_x;
	game_pkg::pos_t joy_y;

	// only one axis steps per cycle, left wins over right over up over down
	always_ff @(posedge clk100hz)
	begin
		if (reset)
		begin
			joy_x <= game_pkg::START_X;
			joy_y <= game_pkg::JOY_Y_MIN;
		end
		else if (left && joy_x != '0)
			joy_x <= joy_x - 10'd1;
		else if (right && joy_x != game_pkg::JOY_X_MAX)
			joy_x <= joy_x + 10'd1;
		else if (up && joy_y != game_pkg::JOY_Y_MIN)
			joy_y <= joy_y - 10'd1;
		else if (down && joy_y != game_pkg::JOY_Y_MAX)
			joy_y <= joy_y + 10'd1;
	end

	// snapshot taken once per frame
	always_ff @(posedge clk100hz)
	begin
		if (frame_tick)
		begin
			cmd.player_x <= joy_x;
			cmd.target <= joy_y;
		end
	end

	always_ff @(posedge clk100hz)
	begin
		if (reset)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= frame_tick;
	end

endmodule

`default_nettype wire

// ==== racing_game_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module racing_game_assertions (
	input wire logic clk100hz,
	input wire logic reset,
	input wire logic frame_tick,
	input wire logic state_valid,
	input game_pkg::game_state_t game_state
);

	// speed can never climb past the highest joystick target
	speed_in_range: assert property (@(posedge clk100hz) disable iff (reset)
		game_state.speed <= 8'd128)
		else $error("speed left its range");

	// every frame strobe comes out of the pipeline exactly four cycles later
	tick_to_valid: assert property (@(posedge clk100hz) disable iff (reset)
		frame_tick |-> ##4 state_valid)
		else $error("state_valid missing four cycles after frame_tick");

	valid_needs_tick: assert property (@(posedge clk100hz) disable iff (reset)
		state_valid |-> $past(frame_tick, 4))
		else $error("state_valid without a frame_tick four cycles before");

endmodule

`default_nettype wire

// ==== racing_game_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module racing_game_core (
	input wire logic clk100hz,
	input wire logic reset,
	input wire logic left,
	input wire logic right,
	input wire logic up,
	input wire logic down,
	input wire logic frame_tick,
	output game_pkg::game_state_t game_state,
	output logic state_valid
);

	game_pkg::player_cmd_t cmd;
	logic cmd_valid;
	game_pkg::hit_cmd_t hit;
	logic hit_valid;
	game_pkg::speed_t speed;
	game_pkg::track_t track_pos;
	game_pkg::pos_t player_x;
	logic collided;
	logic step_valid;

	joy_integrator joy_i (
		.clk100hz(clk100hz),
		.reset(reset),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.frame_tick(frame_tick),
		.cmd(cmd),
		.cmd_valid(cmd_valid)
	);

	// enemy position comes back from the last finished frame
	collision_detector collide_i (
		.clk100hz(clk100hz),
		.reset(reset),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.enemy_x(game_state.enemy_x),
		.enemy_y(game_state.enemy_y),
		.hit(hit),
		.hit_valid(hit_valid)
	);

	speed_governor speed_i (
		.clk100hz(clk100hz),
		.reset(reset),
		.hit(hit),
		.hit_valid(hit_valid),
		.speed(speed),
		.track_pos(track_pos),
		.player_x(player_x),
		.collided(collided),
		.step_valid(step_valid)
	);

	enemy_patrol enemy_i (
		.clk100hz(clk100hz),
		.reset(reset),
		.speed(speed),
		.track_pos(track_pos),
		.player_x(player_x),
		.collided(collided),
		.step_valid(step_valid),
		.state(game_state),
		.state_valid(state_valid)
	);

endmodule

`default_nettype wire

// ==== racing_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module racing_game_tb;

	logic clk100hz;
	logic reset;
	logic left;
	logic right;
	logic up;
	logic down;
	logic frame_tick;
	game_pkg::game_state_t game_state;
	logic state_valid;

	// eight words per vector line
	logic [15:0] vec_mem [0:1023];
	int errors;
	int checks;
	int tick_count;
	int valid_count;
	int line;
	int wait_cycles;
	logic stopped;

	tb_clock_gen clk_gen_i (
		.clk100hz(clk100hz),
		.reset(reset)
	);

	racing_game_core dut_i (
		.clk100hz(clk100hz),
		.reset(reset),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.frame_tick(frame_tick),
		.game_state(game_state),
		.state_valid(state_valid)
	);

	bind racing_game_core racing_game_assertions checks_i (
		.clk100hz(clk100hz),
		.reset(reset),
		.frame_tick(frame_tick),
		.state_valid(state_valid),
		.game_state(game_state)
	);

	task automatic compare_field(input string name, input logic [15:0] got,
		input logic [15:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// an early stop counts as one more error
	task automatic stop_run(input string reason);
		$display("%s", reason);
		errors++;
		stopped = 1'b1;
	endtask

	// ctrl high nibble is left, right, up, down
	// low nibble bit0 tick, bit1 valid expected, bit2 check fields, bit3 ignore valid
	task automatic run_line(input int base);
		logic [7:0] ctrl;
		int rep;
		ctrl = vec_mem[base][7:0];
		rep = int'(vec_mem[base + 1]);
		for (int r = 0; r < rep; r++)
		begin
			@(posedge clk100hz);
			#2;
			left = ctrl[7];
			right = ctrl[6];
			up = ctrl[5];
			down = ctrl[4];
			frame_tick = ctrl[0];
			if (ctrl[0])
				tick_count++;
			@(negedge clk100hz);
			if (state_valid)
				valid_count++;
			if (!ctrl[3])
				compare_field("state_valid", {15'd0, state_valid}, {15'd0, ctrl[1]});
			if (r == rep - 1 && ctrl[2])
			begin
				compare_field("player_x", {6'd0, game_state.player_x}, vec_mem[base + 2]);
				compare_field("enemy_x", {6'd0, game_state.enemy_x}, vec_mem[base + 3]);
				compare_field("enemy_y", {6'd0, game_state.enemy_y}, vec_mem[base + 4]);
				compare_field("speed", {8'd0, game_state.speed}, vec_mem[base + 5]);
				compare_field("track_pos", game_state.track_pos, vec_mem[base + 6]);
				compare_field("collided", {15'd0, game_state.collided}, vec_mem[base + 7]);
			end
		end
	endtask

	initial
	begin
		left = 1'b0;
		right = 1'b0;
		up = 1'b0;
		down = 1'b0;
		frame_tick = 1'b0;
		errors = 0;
		checks = 0;
		tick_count = 0;
		valid_count = 0;
		stopped = 1'b0;
		$readmemh("game_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[0]))
			stop_run("vector file game_vectors.txt could not be read");

		if (!stopped)
		begin
			wait_cycles = 0;
			while (reset !== 1'b0 && wait_cycles < 20)
			begin
				@(posedge clk100hz);
				wait_cycles++;
			end
			if (reset !== 1'b0)
				stop_run("timeout: reset was never released");
		end

		if (!stopped)
		begin
			line = 0;
			while (vec_mem[line * 8] !== 16'h00ff && line < 128)
			begin
				run_line(line * 8);
				line++;
			end

			// every frame that was started must come out of the pipeline
			frame_tick = 1'b0;
			wait_cycles = 0;
			while (valid_count != tick_count && wait_cycles < 50)
			begin
				@(negedge clk100hz);
				if (state_valid)
					valid_count++;
				wait_cycles++;
			end
			if (valid_count != tick_count)
				stop_run("timeout: state_valid missing for some frames");
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== speed_governor.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_governor (
	input wire logic clk100hz,
	input wire logic reset,
	input game_pkg::hit_cmd_t hit,
	input wire logic hit_valid,
	output game_pkg::speed_t speed,
	output game_pkg::track_t track_pos,
	output game_pkg::pos_t player_x,
	output logic collided,
	output logic step_valid
);

	// speed chases the joystick target by one per frame
	logic below_target;

	assign below_target = {2'b00, speed} < hit.target;

	always_ff @(posedge clk100hz)
	begin
		if (reset)
		begin
			speed <= game_pkg::SPEED_INIT;
			track_pos <= '0;
		end
		else if (hit_valid)
		begin
			// track advances with the speed from before this frame
			track_pos <= track_pos + {12'd0, speed[7:4]};
			if (hit.collided)
				speed <= game_pkg::SPEED_CRASH;
			else if (below_target)
				speed <= speed + 8'd1;
			else
				speed <= speed - 8'd1;
		end
	end

	// forwarded to the enemy stage with this frame's result
	always_ff @(posedge clk100hz)
	begin
		if (hit_valid)
		begin
			player_x <= hit.player_x;
			collided <= hit.collided;
		end
	end

	always_ff @(posedge clk100hz)
	begin
		if (reset)
			step_valid <= 1'b0;
		else
			step_valid <= hit_valid;
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk100hz,
	output logic reset
);

	// 40 ns period
	always #20 clk100hz = ~clk100hz;

	initial
	begin
		clk100hz = 1'b0;
		reset = 1'b1;
		// held for two rising edges, released like any other input
		repeat (2) @(posedge clk100hz);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire
